// ==== common/decim_pkg.sv ====
package decim_pkg;

    // sample and coefficient formats
    localparam int SAMPLE_W  = 24;
    localparam int COEF_W    = 18;
    localparam int COEF_FRAC = 17;                  // Q1.17
    localparam int MAX_TAPS  = 32;
    localparam int PROD_W    = SAMPLE_W + COEF_W;
    localparam int FIR_ACC_W = 48;                  // 32 products of 42 bits plus headroom

    // rates
    localparam int CIC_RATE    = 125;
    localparam int CIC_ORDER   = 4;
    localparam int CIC_SHIFT   = 28;                // ceil(4 * log2(125))
    localparam int CIC_ACC_W   = SAMPLE_W + 28;
    localparam int CIC_CNT_W   = $clog2(CIC_RATE);
    localparam int TOTAL_DECIM = 1000;              // 125 * 2 * 2 * 2

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef coef_t [0:MAX_TAPS-1]       coef_table_t;   // tap 0 first, zero padded

    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    // one beat on a link, valid is a single cycle strobe
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        OUTPUT
    } fir_state_t;

    localparam int HB1_TAPS   = 13;
    localparam int HB2_TAPS   = 19;
    localparam int HB3_TAPS   = 27;
    localparam int FINAL_TAPS = 32;

    // kaiser beta 8 half-band, fc = fs/4
    localparam coef_table_t HB1_COEFS = '{
        18'sd0, 18'sd319, 18'sd0, -18'sd5132, 18'sd0, 18'sd37580,
        18'sd65539,
        18'sd37580, 18'sd0, -18'sd5132, 18'sd0, 18'sd319, 18'sd0,
        18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0,
        18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0
    };

    localparam coef_table_t HB2_COEFS = '{
        18'sd11, 18'sd0, -18'sd389, 18'sd0, 18'sd2386, 18'sd0, -18'sd9074, 18'sd0,
        18'sd39834, 18'sd65538, 18'sd39834,
        18'sd0, -18'sd9074, 18'sd0, 18'sd2386, 18'sd0, -18'sd389, 18'sd0, 18'sd11,
        18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0,
        18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0
    };

    localparam coef_table_t HB3_COEFS = '{
        18'sd8, 18'sd0, -18'sd126, 18'sd0, 18'sd593, 18'sd0, -18'sd1850, 18'sd0,
        18'sd4701, 18'sd0, -18'sd11367, 18'sd0, 18'sd40809,
        18'sd65539,
        18'sd40809, 18'sd0, -18'sd11367, 18'sd0, 18'sd4701,
        18'sd0, -18'sd1850, 18'sd0, 18'sd593, 18'sd0, -18'sd126, 18'sd0, 18'sd8,
        18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0
    };

    // equiripple lowpass, pass 150/512, stop 200/512
    localparam coef_table_t FINAL_COEFS = '{
        -18'sd386, -18'sd704, 18'sd415, 18'sd479, -18'sd1264, 18'sd619,
        18'sd1446, -18'sd2726, 18'sd810, 18'sd3538, -18'sd5631, 18'sd951,
        18'sd8896, -18'sd14277, 18'sd1025, 18'sd71609,
        18'sd71609, 18'sd1025, -18'sd14277, 18'sd8896,
        18'sd951, -18'sd5631, 18'sd3538, 18'sd810, -18'sd2726, 18'sd1446,
        18'sd619, -18'sd1264, 18'sd479, 18'sd415, -18'sd704, -18'sd386
    };

endpackage

// ==== cic/cic_decimator.sv ====
`timescale 1ns/1ns

// fourth order CIC, decimate by CIC_RATE, differential delay of one
module cic_decimator import decim_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sample_beat_t in_beat,
    output sample_beat_t out_beat
);

    logic signed [CIC_ACC_W-1:0] integ    [CIC_ORDER];   // wrap freely
    logic signed [CIC_ACC_W-1:0] comb_dly [CIC_ORDER];
    logic signed [CIC_ACC_W-1:0] comb     [CIC_ORDER];
    logic [CIC_CNT_W-1:0]        phase;
    logic                        dec_hit;

    // last input of each block of CIC_RATE
    assign dec_hit = in_beat.valid && (phase == CIC_CNT_W'(CIC_RATE - 1));

    // comb chain, evaluated on the integrator output of the hit cycle
    always_comb begin
        comb[0] = integ[CIC_ORDER-1] - comb_dly[0];
        for (int k = 1; k < CIC_ORDER; k++) begin
            comb[k] = comb[k-1] - comb_dly[k];
        end
    end

    // integrators, advance on input strobes only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < CIC_ORDER; k++) begin
                integ[k] <= '0;
            end
        end else if (in_beat.valid) begin
            integ[0] <= integ[0] + CIC_ACC_W'(in_beat.data);    // sign extended
            for (int k = 1; k < CIC_ORDER; k++) begin
                integ[k] <= integ[k] + integ[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (in_beat.valid) begin
            if (dec_hit) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // comb delays and scaled output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < CIC_ORDER; k++) begin
                comb_dly[k] <= '0;
            end
            out_beat <= '0;
        end else begin
            out_beat.valid <= dec_hit;
            if (dec_hit) begin
                comb_dly[0] <= integ[CIC_ORDER-1];
                for (int k = 1; k < CIC_ORDER; k++) begin
                    comb_dly[k] <= comb[k-1];
                end
                // drop the growth bits, gain ends up at 125^4 / 2^28
                out_beat.data <= comb[CIC_ORDER-1][CIC_SHIFT +: SAMPLE_W];
            end
        end
    end

endmodule

// ==== fir/fir_filter.sv ====
`timescale 1ns/1ns

// single multiplier FIR, taps walked one per cycle
// with DECIM 2 only every second input is computed
module fir_filter import decim_pkg::*; #(
    parameter int          NUM_TAPS = 13,
    parameter coef_table_t COEFS    = '0,
    parameter int          DECIM    = 1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  sample_beat_t in_beat,
    output sample_beat_t out_beat
);

    sample_t                      line [NUM_TAPS];   // line[0] is the newest sample
    logic                         phase;
    logic                         start;
    logic                         start_q;
    fir_state_t                   state;
    logic [$clog2(NUM_TAPS)-1:0]  tap;
    logic                         tap_last;
    logic [$clog2(NUM_TAPS)-1:0]  next_tap;
    logic                         last_q;            // prod_q holds the last product
    logic signed [PROD_W-1:0]     mult;
    logic signed [PROD_W-1:0]     prod_q;
    logic signed [FIR_ACC_W-1:0]  acc;
    logic signed [FIR_ACC_W-1:0]  acc_rnd;
    logic signed [FIR_ACC_W-1:0]  acc_shr;
    sample_t                      sat;

    // second, fourth, ... input starts a run when decimating
    assign start = in_beat.valid && (DECIM == 1 || phase);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                line[i] <= '0;
            end
            phase   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= start;       // line settles before the first multiply
            if (in_beat.valid) begin
                line[0] <= in_beat.data;
                for (int i = 1; i < NUM_TAPS; i++) begin
                    line[i] <= line[i-1];
                end
                phase <= ~phase;
            end
        end
    end

    // the one shared multiplier
    assign mult     = line[tap] * $signed(COEFS[tap]);
    assign tap_last = (int'(tap) == NUM_TAPS - 1);
    assign next_tap = tap_last ? '0 : tap + 1'b1;

    // product is registered, so ACCUM adds the product issued one cycle earlier
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            tap    <= '0;
            last_q <= 1'b0;
            prod_q <= '0;
            acc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_q) begin
                        prod_q <= mult;     // tap 0
                        last_q <= tap_last;
                        tap    <= next_tap;
                        acc    <= '0;
                        state  <= ACCUM;
                    end
                end
                ACCUM: begin
                    acc <= acc + FIR_ACC_W'(prod_q);
                    if (last_q) begin
                        state <= OUTPUT;
                    end else begin
                        prod_q <= mult;
                        last_q <= tap_last;
                        tap    <= next_tap;
                    end
                end
                OUTPUT: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // round half up by COEF_FRAC, then clamp to sample range
    assign acc_rnd = acc + FIR_ACC_W'(1 << (COEF_FRAC - 1));
    assign acc_shr = acc_rnd >>> COEF_FRAC;

    always_comb begin
        if (acc_shr > SAMPLE_MAX) begin
            sat = SAMPLE_MAX;
        end else if (acc_shr < SAMPLE_MIN) begin
            sat = SAMPLE_MIN;
        end else begin
            sat = acc_shr[SAMPLE_W-1:0];
        end
    end

    // strobe in the OUTPUT cycle, NUM_TAPS+2 after the input
    always_comb begin
        out_beat.valid = (state == OUTPUT);
        out_beat.data  = sat;
    end

endmodule

// ==== rtl/down_sample_chain.sv ====
`timescale 1ns/1ns

// CIC /125 then three half-band /2 stages and a final shaping FIR
// overall rate reduction is TOTAL_DECIM
module down_sample_chain import decim_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sample_beat_t in_beat,
    output sample_beat_t out_beat
);

    sample_beat_t cic_beat;     // after /125
    sample_beat_t hb1_beat;     // after /250
    sample_beat_t hb2_beat;     // after /500
    sample_beat_t hb3_beat;     // after /1000

    cic_decimator cic (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (in_beat),
        .out_beat (cic_beat)
    );

    fir_filter #(
        .NUM_TAPS (HB1_TAPS),
        .COEFS    (HB1_COEFS),
        .DECIM    (2)
    ) hb1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (cic_beat),
        .out_beat (hb1_beat)
    );

    fir_filter #(
        .NUM_TAPS (HB2_TAPS),
        .COEFS    (HB2_COEFS),
        .DECIM    (2)
    ) hb2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (hb1_beat),
        .out_beat (hb2_beat)
    );

    fir_filter #(
        .NUM_TAPS (HB3_TAPS),
        .COEFS    (HB3_COEFS),
        .DECIM    (2)
    ) hb3 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (hb2_beat),
        .out_beat (hb3_beat)
    );

    // passband shaping at the output rate, no decimation
    fir_filter #(
        .NUM_TAPS (FINAL_TAPS),
        .COEFS    (FINAL_COEFS),
        .DECIM    (1)
    ) final_fir (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (hb3_beat),
        .out_beat (out_beat)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ns

// free running clock and a power-on reset
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/down_sample_assert.sv ====
`timescale 1ns/1ns

// handshake and strobe rules, bound into each FIR stage and the top level
module down_sample_assert import decim_pkg::*; #(
    parameter bit HAS_SEQ = 1'b1        // target has a FIR sequencer
) (
    input logic         clk,
    input logic         rst_n,
    input sample_beat_t in_beat,
    input sample_beat_t out_beat,
    input fir_state_t   state
);

    // a new sample must never land on a busy sequencer
    if (HAS_SEQ) begin : idle_check
        in_while_idle: assert property (@(posedge clk) disable iff (!rst_n)
            in_beat.valid |-> state == IDLE)
            else $error("input strobe while the FIR sequencer is busy");
    end

    single_cycle_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        out_beat.valid |=> !out_beat.valid)
        else $error("output strobe held for two cycles");

    // registers cleared one edge into reset
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !out_beat.valid)
        else $error("output strobe while in reset");

endmodule

bind fir_filter down_sample_assert fir_checks (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .out_beat (out_beat),
    .state    (state)
);

// no sequencer at the top level, only the strobe rules apply
bind down_sample_chain down_sample_assert #(.HAS_SEQ(1'b0)) chain_checks (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .out_beat (out_beat),
    .state    (IDLE)
);

// ==== bench/down_sample_tb.sv ====
`timescale 1ns/1ns

module down_sample_tb import decim_pkg::*; ();

    localparam int      TIMEOUT_CYCLES = 2_000_000;
    localparam int      STIM_DC        = 0;
    localparam int      STIM_TONE      = 1;
    localparam sample_t DC_POS         = 24'sd1048576;     // 2^20
    localparam sample_t DC_NEG         = -24'sd8388607;    // -(2^23 - 1)
    localparam sample_t TONE_AMP       = 24'sd4194304;     // 2^22

    logic         clk;
    logic         rst_n;
    sample_beat_t in_beat;
    sample_beat_t out_beat;

    int           checks = 0;
    int           errors = 0;
    bit           timed_out = 1'b0;
    logic [31:0]  rng = 32'h8a12_1fe4;
    sample_t      dc_ref;
    sample_t      out_data[$];      // output samples of the last run
    longint       out_strobes[$];   // input strobes driven when each output appeared

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    down_sample_chain down_sample_chain_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (in_beat),
        .out_beat (out_beat)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int table_sum(input coef_table_t t);
        int sum;
        sum = 0;
        for (int i = 0; i < MAX_TAPS; i++) begin
            sum += int'(t[i]);
        end
        return sum;
    endfunction

    // CIC gain R^N / 2^shift times the DC gain of every FIR table
    function automatic real dc_gain();
        real g;
        real unit;
        g = 1.0;
        unit = $itor(1 << COEF_FRAC);
        for (int k = 0; k < CIC_ORDER; k++) begin
            g = g * CIC_RATE;
        end
        g = g / $itor(1 << CIC_SHIFT);
        g = g * $itor(table_sum(HB1_COEFS)) / unit;
        g = g * $itor(table_sum(HB2_COEFS)) / unit;
        g = g * $itor(table_sum(HB3_COEFS)) / unit;
        g = g * $itor(table_sum(FINAL_COEFS)) / unit;
        return g;
    endfunction

    function automatic sample_t stim_value(input int kind, input sample_t level,
                                           input longint idx);
        if (kind == STIM_TONE) begin
            case (idx[1:0])     // A, 0, -A, 0
                2'd0:    return TONE_AMP;
                2'd2:    return -TONE_AMP;
                default: return '0;
            endcase
        end
        return level;
    endfunction

    // drive the input until n_out output strobes are seen
    task automatic collect_outputs(input int n_out, input int kind, input sample_t level,
                                   input bit gaps);
        int     idle_left;
        int     wait_cnt;
        longint strobes;
        idle_left = 0;
        wait_cnt = 0;
        strobes = 0;
        out_data.delete();
        out_strobes.delete();
        while (out_data.size() < n_out && !timed_out) begin
            @(posedge clk);
            if (idle_left > 0) begin
                in_beat.valid <= 1'b0;
                idle_left--;
            end else begin
                in_beat.valid <= 1'b1;
                in_beat.data  <= stim_value(kind, level, strobes);
                strobes++;
                if (gaps) begin
                    rng = xorshift32(rng);
                    idle_left = int'(rng[2:0]);     // 0 to 7 idle cycles
                end
            end
            @(negedge clk);
            if (out_beat.valid) begin
                out_data.push_back(out_beat.data);
                out_strobes.push_back(strobes);
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt >= TIMEOUT_CYCLES) begin
                    $display("timeout: no output strobe within %0d cycles", TIMEOUT_CYCLES);
                    errors++;
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clk);
        in_beat.valid <= 1'b0;
    endtask

    task automatic check_idle_output(input string what);
        checks++;
        assert (!out_beat.valid && out_beat.data == '0) else begin
            $display("error %0t: %s, valid %b data %0d", $time, what,
                     out_beat.valid, out_beat.data);
            errors++;
        end
    endtask

    task automatic check_near(input sample_t got, input real want, input string what);
        real diff;
        diff = $itor(got) - want;
        checks++;
        assert (diff <= 8.0 && diff >= -8.0) else begin
            $display("error %0t: %s got %0d, expected %0.2f", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        int guard;
        guard = 0;
        @(posedge clk);
        while (!rst_n && !timed_out) begin
            @(negedge clk);
            check_idle_output("output active in reset");
            guard++;
            if (guard >= TIMEOUT_CYCLES) begin
                $display("timeout: reset was never released");
                errors++;
                timed_out = 1'b1;
            end
        end
        // no input yet, so the chain stays quiet
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_idle_output("output active after reset");
        end
    endtask

    task automatic measure_output_rate();
        longint step;
        collect_outputs(21, STIM_DC, DC_POS, 1'b0);
        for (int i = 1; i < out_strobes.size(); i++) begin
            step = out_strobes[i] - out_strobes[i-1];
            checks++;
            assert (step == TOTAL_DECIM) else begin
                $display("error %0t: %0d input strobes between outputs %0d and %0d",
                         $time, step, i - 1, i);
                errors++;
            end
        end
    endtask

    task automatic positive_dc_gain();
        real want;
        want = $itor(DC_POS) * dc_gain();
        collect_outputs(60, STIM_DC, DC_POS, 1'b0);
        if (out_data.size() == 60) begin
            dc_ref = out_data[59];      // reused by the pacing test
            check_near(dc_ref, want, "positive dc");
        end
    endtask

    task automatic negative_dc_gain();
        real     want;
        sample_t got;
        want = $itor(DC_NEG) * dc_gain();
        collect_outputs(60, STIM_DC, DC_NEG, 1'b0);
        if (out_data.size() == 60) begin
            got = out_data[59];
            checks++;
            assert (got < 0) else begin
                $display("error %0t: negative dc wrapped to %0d", $time, got);
                errors++;
            end
            check_near(got, want, "negative dc");
        end
    endtask

    task automatic stopband_rejection();
        int mag;
        collect_outputs(80, STIM_TONE, '0, 1'b0);
        for (int i = 60; i < out_data.size(); i++) begin
            mag = int'(out_data[i]);
            if (mag < 0) begin
                mag = -mag;
            end
            checks++;
            assert (mag < int'(TONE_AMP) / 1024) else begin
                $display("error %0t: tone output %0d is %0d", $time, i, out_data[i]);
                errors++;
            end
        end
    endtask

    task automatic irregular_pacing();
        collect_outputs(60, STIM_DC, DC_POS, 1'b1);
        if (out_data.size() == 60) begin
            checks++;
            assert (out_data[59] == dc_ref) else begin
                $display("error %0t: paced dc got %0d, expected %0d", $time,
                         out_data[59], dc_ref);
                errors++;
            end
        end
    endtask

    initial begin
        in_beat = '0;
        check_reset_state();
        if (!timed_out) begin
            measure_output_rate();
        end
        if (!timed_out) begin
            positive_dc_gain();
        end
        if (!timed_out) begin
            negative_dc_gain();
        end
        if (!timed_out) begin
            stopband_rejection();
        end
        if (!timed_out) begin
            irregular_pacing();
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/decim_pkg.sv
cic/cic_decimator.sv
fir/fir_filter.sv
rtl/down_sample_chain.sv
bench/tb_clock_gen.sv
bench/down_sample_assert.sv
bench/down_sample_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module down_sample_tb -f filelist.f \
		-Mdir obj_dir -o down_sample_sim
	./obj_dir/down_sample_sim | tee $(LOG)
	@grep -q "^PASS: all tests" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
